// ==== design/ppu_bg_fetch.sv ====
`include "ppu_defs.svh"

module ppu_bg_fetch (
  input  logic                clk,
  input  logic                rst,
  input  ppu_pkg::ppu_ctrl_t  ctrl,
  input  logic                draw_start,
  input  ppu_pkg::ly_t        ly,
  output ppu_pkg::vram_addr_t vram_addr,
  output logic                vram_rd,
  input  ppu_pkg::u8_t        vram_data,
  input  logic                fifo_full,
  output logic                fifo_push,
  output ppu_pkg::pixel_t     pix,
  output logic                line_done
);

  ppu_pkg::fetch_state_t state;
  ppu_pkg::ly_t          line_y;     // Screen line being drawn
  ppu_pkg::u8_t          bg_y;       // LY + SCY
  logic [4:0]            tile_col;   // Map column, wraps at 32
  ppu_pkg::u8_t          tile_idx;
  ppu_pkg::u8_t          data_tile;  // Tile number for the data reads
  ppu_pkg::u8_t          data_lo;
  logic [7:0]            sh_lo;
  logic [7:0]            sh_hi;
  logic                  load;       // High byte arrives this cycle
  logic [2:0]            discard;
  logic [2:0]            bit_cnt;
  ppu_pkg::px_t          out_x;
  ppu_pkg::color_t       color;
  logic                  shift;
  logic                  last_px;

  // ------------------------------
  // VRAM addressing
  assign data_tile = (state == ppu_pkg::LO) ? vram_data : tile_idx;  // Map byte lands in LO

  always_comb begin
    vram_rd   = 1'b0;
    vram_addr = '0;
    case (state)
      ppu_pkg::MAP: begin
        vram_rd   = 1'b1;
        vram_addr = {2'b11, ctrl.lcdc[3], bg_y[7:3], tile_col};  // 9800 or 9C00
      end
      ppu_pkg::LO, ppu_pkg::HI: begin
        vram_rd   = 1'b1;
        // Signed mode puts tiles 0 to 127 at 9000
        vram_addr = {~ctrl.lcdc[4] & ~data_tile[7], data_tile, bg_y[2:0],
                     state == ppu_pkg::HI};
      end
      default: ;
    endcase
  end

  // ------------------------------
  // Pixel shifter
  assign color     = ctrl.lcdc[0] ? {sh_hi[7], sh_lo[7]} : 2'b00;
  assign shift     = (state == ppu_pkg::PUSH) && !load && ((discard != 3'd0) || !fifo_full);
  assign fifo_push = (state == ppu_pkg::PUSH) && !load && (discard == 3'd0) && !fifo_full;
  assign last_px   = out_x == 8'(`PPU_SCREEN_W - 1);
  assign pix       = '{x: out_x, y: line_y, shade: ctrl.bgp[{color, 1'b0} +: 2]};

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ppu_pkg::IDLE;
      load      <= 1'b0;
      line_done <= 1'b0;
    end else begin
      load      <= state == ppu_pkg::HI;
      line_done <= 1'b0;
      if (!ctrl.lcdc[7]) begin
        state <= ppu_pkg::IDLE;
      end else begin
        case (state)
          ppu_pkg::IDLE: if (draw_start) state <= ppu_pkg::MAP;
          ppu_pkg::MAP:  state <= ppu_pkg::LO;
          ppu_pkg::LO:   state <= ppu_pkg::HI;
          ppu_pkg::HI:   state <= ppu_pkg::PUSH;
          ppu_pkg::PUSH: begin
            if (fifo_push && last_px) begin
              state     <= ppu_pkg::IDLE;
              line_done <= 1'b1;   // After the 160th push
            end else if (shift && bit_cnt == 3'd7) begin
              state <= ppu_pkg::MAP;
            end
          end
          default: state <= ppu_pkg::IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (draw_start) begin
      line_y   <= ly;
      bg_y     <= ly + ctrl.scy;
      tile_col <= ctrl.scx[7:3];
      discard  <= ctrl.scx[2:0];   // Fine scroll
      out_x    <= '0;
    end
    if (state == ppu_pkg::LO) tile_idx <= vram_data;
    if (state == ppu_pkg::HI) data_lo <= vram_data;
    if (load) begin
      sh_lo   <= data_lo;
      sh_hi   <= vram_data;
      bit_cnt <= '0;
    end else if (shift) begin
      sh_lo   <= sh_lo << 1;
      sh_hi   <= sh_hi << 1;
      bit_cnt <= bit_cnt + 3'd1;
      if (discard != 3'd0) discard <= discard - 3'd1;
      if (fifo_push) out_x <= out_x + 8'd1;
      if (bit_cnt == 3'd7) tile_col <= tile_col + 5'd1;
    end
  end

  // A new line starts only once the previous one has finished
  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    draw_start |-> state == ppu_pkg::IDLE);

endmodule

// ==== design/ppu_defs.svh ====
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// ------------------------------
// Display format
`define PPU_SCREEN_W        160   // Visible pixels per line
`define PPU_SCREEN_H        144   // Visible lines
`define PPU_DOTS_PER_LINE   456
`define PPU_LINES_PER_FRAME 154
`define PPU_OAM_DOTS        80    // Mode 2 length in dots

// ------------------------------
// Pixel output side
`define PPU_PIX_CREDITS     4     // Credits held after reset
`define PPU_FIFO_DEPTH      8

// ------------------------------
// CPU register window at FF40
`define PPU_REG_BASE        16'hFF40
`define PPU_REG_LCDC        4'h0
`define PPU_REG_STAT        4'h1
`define PPU_REG_SCY         4'h2
`define PPU_REG_SCX         4'h3
`define PPU_REG_LY          4'h4
`define PPU_REG_LYC         4'h5
`define PPU_REG_DMA         4'h6
`define PPU_REG_BGP         4'h7
`define PPU_REG_OBP0        4'h8
`define PPU_REG_OBP1        4'h9
`define PPU_REG_WY          4'hA
`define PPU_REG_WX          4'hB

`endif

// ==== design/ppu_pix_out.sv ====
`include "ppu_defs.svh"

module ppu_pix_out (
  input  logic            clk,
  input  logic            rst,
  input  logic            fifo_push,
  input  ppu_pkg::pixel_t pix_in,
  output logic            fifo_full,
  output logic            pix_valid,
  output ppu_pkg::pixel_t pix,
  input  logic            pix_credit
);

  localparam int PTR_W = $clog2(`PPU_FIFO_DEPTH);
  localparam int CRD_W = $clog2(`PPU_PIX_CREDITS + 1);

  ppu_pkg::pixel_t  mem [`PPU_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic [CRD_W-1:0] credits;   // Free slots on the sink side
  logic             pop;

  // ------------------------------
  // FIFO status and output
  assign fifo_full = count == (PTR_W + 1)'(`PPU_FIFO_DEPTH);
  assign pop       = (count != '0) && (credits != '0);
  assign pix_valid = pop;           // One cycle after the push into an empty FIFO
  assign pix       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (fifo_push) begin
      mem[wr_ptr] <= pix_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRD_W'(`PPU_PIX_CREDITS);
    end else begin
      if (fifo_push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;

      case ({fifo_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase

      // Each pixel sent costs a credit, each pulse returns one
      case ({pop, pix_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  // Sink never returns more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= CRD_W'(`PPU_PIX_CREDITS));

endmodule

// ==== design/ppu_pkg.sv ====
package ppu_pkg;

  typedef logic [7:0]  u8_t;         // Register byte
  typedef logic [15:0] u16_t;        // CPU or VRAM address
  typedef logic [12:0] vram_addr_t;  // Byte offset from 8000
  typedef logic [7:0]  ly_t;
  typedef logic [7:0]  px_t;
  typedef logic [1:0]  shade_t;      // Gray level after palette
  typedef logic [1:0]  color_t;      // Raw color index from tile data

  // Same encoding as the STAT mode bits
  typedef enum logic [1:0] {
    HBLANK = 2'd0,
    VBLANK = 2'd1,
    OAM    = 2'd2,
    DRAW   = 2'd3
  } ppu_mode_t;

  typedef enum logic [2:0] {
    IDLE,
    MAP,
    LO,
    HI,
    PUSH
  } fetch_state_t;

  typedef struct packed {
    u16_t addr;
    u8_t  wdata;
    logic wr;
    logic rd;
  } cpu_bus_t;

  // Register values needed by timing and fetcher
  typedef struct packed {
    u8_t lcdc;
    u8_t scy;
    u8_t scx;
    u8_t lyc;
    u8_t bgp;
  } ppu_ctrl_t;

  typedef struct packed {
    ppu_mode_t mode;
    ly_t       ly;
    logic      lyc_match;
  } ppu_status_t;

  typedef struct packed {
    px_t    x;
    ly_t    y;
    shade_t shade;
  } pixel_t;

endpackage

// ==== design/ppu_regs.sv ====
`include "ppu_defs.svh"

module ppu_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  ppu_pkg::cpu_bus_t    bus,
  input  ppu_pkg::ppu_status_t status,
  output ppu_pkg::u8_t         rd_data,
  output ppu_pkg::ppu_ctrl_t   ctrl,
  output ppu_pkg::u8_t         stat_en
);

  ppu_pkg::u8_t  lcdc;
  ppu_pkg::u8_t  stat;   // Only bits 6:3 are kept
  ppu_pkg::u8_t  scy;
  ppu_pkg::u8_t  scx;
  ppu_pkg::u8_t  lyc;
  ppu_pkg::u8_t  dma;
  ppu_pkg::u8_t  bgp;
  ppu_pkg::u8_t  obp0;
  ppu_pkg::u8_t  obp1;
  ppu_pkg::u8_t  wy;
  ppu_pkg::u8_t  wx;

  ppu_pkg::u16_t rel;    // Address relative to FF40
  logic          hit;
  logic [3:0]    offset;
  ppu_pkg::u8_t  rd_mux;

  // Below FF40 the subtraction wraps to a large value
  assign rel    = bus.addr - `PPU_REG_BASE;
  assign hit    = rel <= 16'(`PPU_REG_WX);
  assign offset = rel[3:0];

  // ------------------------------
  // Register writes
  always_ff @(posedge clk) begin
    if (rst) begin
      lcdc <= 8'h91;
      stat <= 8'h00;
      scy  <= 8'h00;
      scx  <= 8'h00;
      lyc  <= 8'h00;
      dma  <= 8'h00;
      bgp  <= 8'hFC;
      obp0 <= 8'hFF;
      obp1 <= 8'hFF;
      wy   <= 8'h00;
      wx   <= 8'h00;
    end else if (bus.wr && hit) begin
      case (offset)
        `PPU_REG_LCDC: lcdc <= bus.wdata;
        `PPU_REG_STAT: stat <= {1'b0, bus.wdata[6:3], 3'b000};  // Interrupt enables only
        `PPU_REG_SCY:  scy  <= bus.wdata;
        `PPU_REG_SCX:  scx  <= bus.wdata;
        `PPU_REG_LYC:  lyc  <= bus.wdata;
        `PPU_REG_DMA:  dma  <= bus.wdata;
        `PPU_REG_BGP:  bgp  <= bus.wdata;
        `PPU_REG_OBP0: obp0 <= bus.wdata;
        `PPU_REG_OBP1: obp1 <= bus.wdata;
        `PPU_REG_WY:   wy   <= bus.wdata;
        `PPU_REG_WX:   wx   <= bus.wdata;
        default: ;                                             // LY is read-only
      endcase
    end
  end

  // ------------------------------
  // Read-back, live state merged into STAT and LY
  always_comb begin
    rd_mux = 8'hFF;
    if (hit) begin
      case (offset)
        `PPU_REG_LCDC: rd_mux = lcdc;
        `PPU_REG_STAT: rd_mux = {1'b1, stat[6:3], status.lyc_match, status.mode};
        `PPU_REG_SCY:  rd_mux = scy;
        `PPU_REG_SCX:  rd_mux = scx;
        `PPU_REG_LY:   rd_mux = status.ly;
        `PPU_REG_LYC:  rd_mux = lyc;
        `PPU_REG_DMA:  rd_mux = dma;
        `PPU_REG_BGP:  rd_mux = bgp;
        `PPU_REG_OBP0: rd_mux = obp0;
        `PPU_REG_OBP1: rd_mux = obp1;
        `PPU_REG_WY:   rd_mux = wy;
        `PPU_REG_WX:   rd_mux = wx;
        default:       rd_mux = 8'hFF;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bus.rd) begin
      rd_data <= rd_mux;
    end
  end

  assign ctrl    = '{lcdc: lcdc, scy: scy, scx: scx, lyc: lyc, bgp: bgp};
  assign stat_en = stat;

endmodule

// ==== design/ppu_timing.sv ====
`include "ppu_defs.svh"

module ppu_timing (
  input  logic                 clk,
  input  logic                 rst,
  input  ppu_pkg::ppu_ctrl_t   ctrl,
  input  ppu_pkg::u8_t         stat_en,
  input  logic                 line_done,
  output ppu_pkg::ppu_status_t status,
  output logic                 draw_start,
  output logic                 vblank_int,
  output logic                 stat_int
);

  ppu_pkg::ppu_mode_t mode;
  ppu_pkg::ly_t       ly;
  ppu_pkg::ly_t       ly_next;
  logic [8:0]         dot;
  logic               lcd_on;
  logic               lcd_on_q;    // Low for one cycle after re-enable
  logic               line_end;    // Last dot and free to wrap
  logic               enter_draw;
  logic               lyc_match;
  logic               stat_src;
  logic               stat_src_q;

  assign lcd_on     = ctrl.lcdc[7];
  assign line_end   = (dot == 9'(`PPU_DOTS_PER_LINE - 1)) && (mode != ppu_pkg::DRAW);
  assign ly_next    = (ly == 8'(`PPU_LINES_PER_FRAME - 1)) ? 8'd0 : ly + 8'd1;
  assign enter_draw = lcd_on && lcd_on_q && (mode == ppu_pkg::OAM) &&
                      (dot == 9'(`PPU_OAM_DOTS - 1));
  assign lyc_match  = ly == ctrl.lyc;

  // ------------------------------
  // Dot, line and mode
  always_ff @(posedge clk) begin
    if (rst) begin
      dot      <= '0;
      ly       <= '0;
      mode     <= ppu_pkg::OAM;
      lcd_on_q <= 1'b1;
    end else if (!lcd_on) begin
      dot      <= '0;
      ly       <= '0;
      mode     <= ppu_pkg::HBLANK;
      lcd_on_q <= 1'b0;
    end else if (!lcd_on_q) begin
      mode     <= ppu_pkg::OAM;  // Line 0 starts over at dot 0
      lcd_on_q <= 1'b1;
    end else if (line_end) begin
      dot  <= '0;
      ly   <= ly_next;
      mode <= (ly_next >= 8'(`PPU_SCREEN_H)) ? ppu_pkg::VBLANK : ppu_pkg::OAM;
    end else begin
      // Holds at the last dot while a stalled DRAW finishes
      if (dot != 9'(`PPU_DOTS_PER_LINE - 1)) begin
        dot <= dot + 9'd1;
      end
      case (mode)
        ppu_pkg::OAM:  if (enter_draw) mode <= ppu_pkg::DRAW;
        ppu_pkg::DRAW: if (line_done) mode <= ppu_pkg::HBLANK;
        default: ;
      endcase
    end
  end

  // ------------------------------
  // Interrupt pulses
  always_comb begin
    stat_src = (lyc_match && stat_en[6]) ||
               ((mode == ppu_pkg::OAM) && stat_en[5]) ||
               ((mode == ppu_pkg::VBLANK) && stat_en[4]) ||
               ((mode == ppu_pkg::HBLANK) && stat_en[3]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stat_src_q <= 1'b0;
      stat_int   <= 1'b0;
      vblank_int <= 1'b0;
      draw_start <= 1'b0;
    end else begin
      stat_src_q <= lcd_on && stat_src;
      stat_int   <= lcd_on && stat_src && !stat_src_q;  // Rising edge only
      vblank_int <= lcd_on && lcd_on_q && line_end && (ly == 8'(`PPU_SCREEN_H - 1));
      draw_start <= enter_draw;                          // First DRAW cycle
    end
  end

  assign status = '{mode: mode, ly: ly, lyc_match: lyc_match};

  // A line leaves DRAW only through HBLANK
  a_draw_exit: assert property (@(posedge clk) disable iff (rst)
    mode == ppu_pkg::DRAW |=> mode inside {ppu_pkg::DRAW, ppu_pkg::HBLANK});

endmodule

// ==== design/ppu_top.sv ====
module ppu_top (
  input  logic                clk,
  input  logic                rst,
  input  ppu_pkg::cpu_bus_t   bus,
  output ppu_pkg::u8_t        rd_data,
  output ppu_pkg::vram_addr_t vram_addr,
  output logic                vram_rd,
  input  ppu_pkg::u8_t        vram_data,
  output logic                pix_valid,
  output ppu_pkg::pixel_t     pix,
  input  logic                pix_credit,
  output logic                vblank_int,
  output logic                stat_int
);

  ppu_pkg::ppu_ctrl_t   ctrl;
  ppu_pkg::ppu_status_t status;
  ppu_pkg::u8_t         stat_en;     // Stored STAT byte
  ppu_pkg::pixel_t      bg_pix;
  logic                 draw_start;
  logic                 line_done;
  logic                 fifo_push;
  logic                 fifo_full;

  // ------------------------------
  // Input side
  ppu_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .bus     (bus),
    .status  (status),
    .rd_data (rd_data),
    .ctrl    (ctrl),
    .stat_en (stat_en)
  );

  // ------------------------------
  // Line timing and background
  ppu_timing u_timing (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .stat_en    (stat_en),
    .line_done  (line_done),
    .status     (status),
    .draw_start (draw_start),
    .vblank_int (vblank_int),
    .stat_int   (stat_int)
  );

  ppu_bg_fetch u_fetch (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .draw_start (draw_start),
    .ly         (status.ly),
    .vram_addr  (vram_addr),
    .vram_rd    (vram_rd),
    .vram_data  (vram_data),
    .fifo_full  (fifo_full),
    .fifo_push  (fifo_push),
    .pix        (bg_pix),
    .line_done  (line_done)
  );

  // ------------------------------
  // Output side
  ppu_pix_out u_out (
    .clk        (clk),
    .rst        (rst),
    .fifo_push  (fifo_push),
    .pix_in     (bg_pix),
    .fifo_full  (fifo_full),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .pix_credit (pix_credit)
  );

endmodule

// ==== ppu_sys.f ====
+incdir+design
design/ppu_pkg.sv
design/ppu_regs.sv
design/ppu_timing.sv
design/ppu_bg_fetch.sv
design/ppu_pix_out.sv
design/ppu_top.sv
tests/tb_clock.sv
tests/ppu_tb.sv

// ==== tests/ppu_tb.sv ====
`include "ppu_defs.svh"

module ppu_tb;

  logic                clk;
  logic                rst;
  ppu_pkg::cpu_bus_t   bus;
  ppu_pkg::u8_t        rd_data;
  ppu_pkg::vram_addr_t vram_addr;
  logic                vram_rd;
  ppu_pkg::u8_t        vram_data;
  logic                pix_valid;
  ppu_pkg::pixel_t     pix;
  logic                pix_credit;
  logic                vblank_int;
  logic                stat_int;

  ppu_pkg::u8_t        vram [8192];
  ppu_pkg::vram_addr_t req_addr;
  logic                req_rd;
  ppu_pkg::pixel_t     got [$];       // Pixels taken by the sink
  int                  due [$];       // Cycle at which each credit goes back
  int                  cycle;
  int                  credit_delay;
  int                  in_flight;     // Pixels taken, credit not yet returned
  int                  peak;
  int                  errors;
  int                  passed;
  int                  failed;
  ppu_pkg::u8_t        lcdc_w;        // Register values as written
  ppu_pkg::u8_t        scy_w;
  ppu_pkg::u8_t        scx_w;
  ppu_pkg::u8_t        bgp_w;

  tb_clock u_clock (.clk(clk));

  ppu_top DUT (
    .clk        (clk),
    .rst        (rst),
    .bus        (bus),
    .rd_data    (rd_data),
    .vram_addr  (vram_addr),
    .vram_rd    (vram_rd),
    .vram_data  (vram_data),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .pix_credit (pix_credit),
    .vblank_int (vblank_int),
    .stat_int   (stat_int)
  );

  // ------------------------------
  // VRAM, data one cycle after the read
  always @(posedge clk) begin
    req_rd   <= vram_rd;
    req_addr <= vram_addr;
  end

  always @(negedge clk) begin
    if (req_rd) vram_data = vram[req_addr];
  end

  // ------------------------------
  // Pixel sink with delayed credit return
  always @(posedge clk) begin
    if (pix_valid) begin
      got.push_back(pix);
      due.push_back(cycle + credit_delay);
      in_flight++;
    end
    if (pix_credit) in_flight--;
    if (in_flight > peak) peak = in_flight;
    cycle++;
  end

  always @(negedge clk) begin
    pix_credit = 1'b0;
    if (due.size() > 0 && due[0] <= cycle) begin
      due.delete(0);
      pix_credit = 1'b1;                      // One credit per cycle at most
    end
  end

  function automatic ppu_pkg::u16_t reg_addr(input int off);
    return `PPU_REG_BASE + 16'(off);
  endfunction

  function automatic ppu_pkg::u8_t reset_value(input int off);
    case (off)
      0:       return 8'h91;
      1:       return 8'h86;                  // Mode OAM, LY equals LYC
      7:       return 8'hFC;
      8, 9:    return 8'hFF;
      default: return 8'h00;
    endcase
  endfunction

  // Background shade of screen pixel (x, y) from VRAM and the written registers
  function automatic ppu_pkg::shade_t model_shade(input int x, input int y);
    int bx;
    int by;
    int tile;
    int base;
    int color;
    bx   = (x + scx_w) % 256;
    by   = (y + scy_w) % 256;
    tile = vram[(lcdc_w[3] ? 'h1C00 : 'h1800) + (by / 8) * 32 + bx / 8];
    if (lcdc_w[4]) begin
      base = tile * 16;
    end else begin
      base = 4096 + (tile < 128 ? tile : tile - 256) * 16;  // Signed, centered on 9000
    end
    base  = base + (by % 8) * 2;
    color = lcdc_w[0] ? 2 * vram[base + 1][7 - bx % 8] + vram[base][7 - bx % 8] : 0;
    return bgp_w[2 * color +: 2];
  endfunction

  task automatic cpu_write(input ppu_pkg::u16_t addr, input ppu_pkg::u8_t data);
    @(negedge clk);
    bus.addr  = addr;
    bus.wdata = data;
    bus.wr    = 1'b1;
    @(negedge clk);
    bus.wr = 1'b0;
    if (addr == reg_addr(`PPU_REG_LCDC)) lcdc_w = data;
    if (addr == reg_addr(`PPU_REG_SCY)) scy_w = data;
    if (addr == reg_addr(`PPU_REG_SCX)) scx_w = data;
    if (addr == reg_addr(`PPU_REG_BGP)) bgp_w = data;
  endtask

  task automatic cpu_read(input ppu_pkg::u16_t addr, output ppu_pkg::u8_t data);
    @(negedge clk);
    bus.addr = addr;
    bus.rd   = 1'b1;
    @(negedge clk);
    bus.rd = 1'b0;
    data   = rd_data;
  endtask

  task automatic wait_vblank();
    int n;
    n = 0;
    @(negedge clk);
    while (!vblank_int && n < 400000) begin
      @(negedge clk);
      n++;
    end
    if (!vblank_int) begin
      $display("Timeout: vblank_int never pulsed, time %0t", $time);
      errors++;
    end
  endtask

  // Finds the start of line y (or takes the next pixel if strict), then checks 160 pixels
  task automatic compare_line(input int y, input bit strict);
    ppu_pkg::pixel_t p;
    int x;
    int n;
    int skipped;
    bit found;
    bit bad;
    x       = 0;
    skipped = 0;
    found   = 1'b0;
    bad     = 1'b0;
    while (x < `PPU_SCREEN_W && !bad) begin
      n = 0;
      while (got.size() == 0 && n < 400000) begin
        @(negedge clk);
        n++;
      end
      if (got.size() == 0 || skipped > 60000) begin
        $display("Timeout: line %0d stalled at pixel %0d, time %0t", y, x, $time);
        errors++;
        bad = 1'b1;
      end else begin
        p = got.pop_front();
        if (found || strict || (p.x == 8'd0 && p.y == 8'(y))) begin
          found = 1'b1;
          if (p.x != 8'(x) || p.y != 8'(y) || p.shade != model_shade(x, y)) begin
            $display("[ERROR] %0t: pixel (%0d,%0d) shade %0d, expected (%0d,%0d) shade %0d",
                     $time, p.x, p.y, p.shade, x, y, model_shade(x, y));
            errors++;
            bad = 1'b1;
          end
          x++;
        end else begin
          skipped++;
        end
      end
    end
  endtask

  task automatic log_result(input string name, input int start);
    if (errors == start) begin
      passed++;
      $display("PASS  %s", name);
    end else begin
      failed++;
      $display("FAIL  %s (%0d errors)", name, errors - start);
    end
  endtask

  // ------------------------------
  // Directed tests
  task automatic reset_values();
    ppu_pkg::u8_t d;
    int start;
    int off;
    start = errors;
    for (off = 0; off < 12; off++) begin
      cpu_read(reg_addr(off), d);
      if (d != reset_value(off)) begin
        $display("[ERROR] %0t: register %0d reads %h after reset, expected %h",
                 $time, off, d, reset_value(off));
        errors++;
      end
    end
    log_result("reset values", start);
  endtask

  task automatic register_access();
    ppu_pkg::u8_t d;
    ppu_pkg::u8_t exp;
    int start;
    int off;
    start = errors;
    cpu_write(reg_addr(`PPU_REG_STAT), 8'h07);  // Low bits must not stick
    cpu_read(reg_addr(`PPU_REG_STAT), d);
    if (d != 8'h86) begin
      $display("[ERROR] %0t: STAT reads %h, expected 86", $time, d);
      errors++;
    end
    cpu_write(reg_addr(`PPU_REG_STAT), 8'h78);
    cpu_read(reg_addr(`PPU_REG_STAT), d);
    if (d[7:3] != 5'b11111) begin
      $display("[ERROR] %0t: STAT reads %h, expected F8 in bits 7:3", $time, d);
      errors++;
    end
    for (off = 2; off < 12; off++) begin
      cpu_write(reg_addr(off), off == `PPU_REG_LY ? 8'h99 : {4'(off), ~4'(off)});
    end
    for (off = 2; off < 12; off++) begin
      exp = (off == `PPU_REG_LY) ? 8'h00 : {4'(off), ~4'(off)};  // Still in line 0
      cpu_read(reg_addr(off), d);
      if (d != exp) begin
        $display("[ERROR] %0t: register %0d reads %h, expected %h", $time, off, d, exp);
        errors++;
      end
    end
    cpu_read(16'hFF3F, d);
    if (d != 8'hFF) begin
      $display("[ERROR] %0t: FF3F reads %h, expected FF", $time, d);
      errors++;
    end
    cpu_read(16'hFF4C, d);
    if (d != 8'hFF) begin
      $display("[ERROR] %0t: FF4C reads %h, expected FF", $time, d);
      errors++;
    end
    log_result("register access", start);
  endtask

  task automatic frame_pixels();
    int start;
    start = errors;
    cpu_write(reg_addr(`PPU_REG_SCY), 8'h2D);
    cpu_write(reg_addr(`PPU_REG_SCX), 8'h13);
    cpu_write(reg_addr(`PPU_REG_BGP), 8'h1B);
    cpu_write(reg_addr(`PPU_REG_LCDC), 8'h89);  // 9C00 map, signed tiles at 9000
    wait_vblank();
    got.delete();
    compare_line(0, 1'b0);
    compare_line(70, 1'b0);
    compare_line(71, 1'b1);
    compare_line(143, 1'b0);
    log_result("frame pixels", start);
  endtask

  task automatic back_pressure();
    int start;
    start = errors;
    cpu_write(reg_addr(`PPU_REG_SCY), 8'hF8);   // Wraps past row 255
    cpu_write(reg_addr(`PPU_REG_SCX), 8'hB5);   // Map columns wrap at 32
    cpu_write(reg_addr(`PPU_REG_BGP), 8'hE4);
    cpu_write(reg_addr(`PPU_REG_LCDC), 8'h91);
    wait_vblank();
    credit_delay = 50;
    peak = 0;
    got.delete();
    compare_line(10, 1'b0);
    compare_line(11, 1'b1);
    credit_delay = 2;
    if (peak > `PPU_PIX_CREDITS) begin
      $display("[ERROR] %0t: %0d pixels unacknowledged, limit %0d",
               $time, peak, `PPU_PIX_CREDITS);
      errors++;
    end
    log_result("back-pressure", start);
  endtask

  task automatic interrupt_pulses();
    ppu_pkg::u8_t d;
    int start;
    int n;
    int vb_n;
    int st_n;
    start = errors;
    cpu_write(reg_addr(`PPU_REG_LYC), 8'h40);
    cpu_write(reg_addr(`PPU_REG_STAT), 8'h40);  // LY=LYC source only
    wait_vblank();
    n    = 0;
    vb_n = 0;
    st_n = 0;
    while (vb_n < 2 && n < 400000) begin
      @(negedge clk);
      n++;
      if (stat_int) begin
        st_n++;
        cpu_read(reg_addr(`PPU_REG_LY), d);
        if (d != 8'h40) begin
          $display("[ERROR] %0t: LY reads %0d after stat_int, expected 64", $time, d);
          errors++;
        end
      end
      if (vblank_int) begin
        vb_n++;
        cpu_read(reg_addr(`PPU_REG_LY), d);
        if (d != 8'd144) begin
          $display("[ERROR] %0t: LY reads %0d after vblank_int, expected 144", $time, d);
          errors++;
        end
      end
    end
    if (vb_n < 2) begin
      $display("Timeout: only %0d vblank pulses in two frames, time %0t", vb_n, $time);
      errors++;
    end
    if (st_n != 2) begin
      $display("[ERROR] %0t: %0d stat_int pulses in two frames, expected 2", $time, st_n);
      errors++;
    end
    log_result("interrupts", start);
  endtask

  task automatic display_off();
    ppu_pkg::u8_t d;
    int start;
    int n;
    int quiet;
    int vb_n;
    int st_n;
    start = errors;
    cpu_write(reg_addr(`PPU_REG_LCDC), 8'h11);
    n     = 0;
    quiet = 0;
    while (quiet < 50 && n < 2000) begin     // Pixel FIFO drains
      @(negedge clk);
      n++;
      if (got.size() != 0) begin
        got.delete();
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    if (quiet < 50) begin
      $display("Timeout: pixels kept arriving after display off, time %0t", $time);
      errors++;
    end
    vb_n = 0;
    st_n = 0;
    // A whole frame, long enough for pixels, vblank and the LYC line
    repeat (`PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME) begin
      @(negedge clk);
      if (vblank_int) vb_n++;
      if (stat_int) st_n++;
    end
    if (got.size() != 0 || vb_n != 0 || st_n != 0) begin
      $display("[ERROR] %0t: display off gave %0d pixels, %0d vblank, %0d stat pulses",
               $time, got.size(), vb_n, st_n);
      errors++;
    end
    cpu_read(reg_addr(`PPU_REG_LY), d);
    if (d != 8'h00) begin
      $display("[ERROR] %0t: LY reads %0d with display off, expected 0", $time, d);
      errors++;
    end
    cpu_read(reg_addr(`PPU_REG_STAT), d);
    if (d != 8'hC0) begin
      $display("[ERROR] %0t: STAT reads %h with display off, expected C0", $time, d);
      errors++;
    end
    cpu_write(reg_addr(`PPU_REG_LCDC), 8'h91);
    compare_line(0, 1'b1);                    // First pixel must open line 0
    log_result("display off", start);
  endtask

  initial begin
    int i;
    void'($urandom(32'hc028));
    for (i = 0; i < 8192; i++) begin
      vram[i] = 8'($urandom);
    end
    rst          = 1'b1;
    bus          = '0;
    vram_data    = 8'h00;
    pix_credit   = 1'b0;
    req_rd       = 1'b0;
    cycle        = 0;
    credit_delay = 2;
    in_flight    = 0;
    peak         = 0;
    errors       = 0;
    passed       = 0;
    failed       = 0;
    lcdc_w       = 8'h91;
    scy_w        = 8'h00;
    scx_w        = 8'h00;
    bgp_w        = 8'hFC;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    reset_values();
    register_access();
    frame_pixels();
    back_pressure();
    interrupt_pulses();
    display_off();

    $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
  output logic clk
);

  // Period of 40
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule
